// ==== flist.f ====
+incdir+.
pp_io_pkg.sv
pp_isa_pkg.sv
pp_decode.sv
pp_execute.sv
pp_sequencer.sv
pp_output_stage.sv
pp_core.sv
tb_pp_core.sv

// ==== tb_pp_programs.svh ====
`ifndef TB_PP_PROGRAMS_SVH
`define TB_PP_PROGRAMS_SVH

////////////////////////////////////////////////////////////
// test programs and expected results
////////////////////////////////////////////////////////////

localparam int NUM_ROWS = 8;
localparam int PROG_LEN = 16;
localparam int NUM_DATA = 4;
localparam int MAX_DDS  = 4;

typedef struct packed
{
	logic [7:0]  bp_lvl;    // ready low when 7 random bits fall below this
	logic        pmt;
	logic [15:0] stop_at;   // cycles after start for stop_i, 0 for none
	logic [15:0] delay;     // wait cycles, for the run limit
} stim_t;

typedef struct packed
{
	pp_io_pkg::word_t    w;
	logic [13:0]         addr;
	pp_io_pkg::word_t    val;
	pp_io_pkg::shutter_t shutter;
} result_t;

pp_io_pkg::word_t    prog [NUM_ROWS][PROG_LEN];
int                  prog_len [NUM_ROWS];
logic [13:0]         data_addr [NUM_ROWS][NUM_DATA];
pp_io_pkg::word_t    data_val [NUM_ROWS][NUM_DATA];
stim_t               stim [NUM_ROWS];
result_t             exp_res [NUM_ROWS];
int                  num_dds [NUM_ROWS];
pp_io_pkg::dds_cmd_t exp_dds [NUM_ROWS][MAX_DDS];

task automatic load_table();
	int r;
	int k;
	for (r = 0; r < NUM_ROWS; r++)
	begin
		for (k = 0; k < NUM_DATA; k++)
		begin
			data_addr[r][k] = 14'h3FFF;   // unused slot
			data_val[r][k]  = fill_word(14'h3FFF);
		end
		for (k = 0; k < MAX_DDS; k++)
			exp_dds[r][k] = '0;
		num_dds[r] = 0;
	end

	// arithmetic chain
	prog[0][0] = encode(pp_isa_pkg::op_ldwrd, 24'h001234);
	prog[0][1] = encode(pp_isa_pkg::op_addw,  24'h000100);
	prog[0][2] = encode(pp_isa_pkg::op_sub,   24'h000101);
	prog[0][3] = encode(pp_isa_pkg::op_mul,   24'h000102);
	prog[0][4] = encode(pp_isa_pkg::op_shl,   24'h000103);
	prog[0][5] = encode(pp_isa_pkg::op_shrd,  24'h00000C);   // W negative here
	prog[0][6] = encode(pp_isa_pkg::op_andwd, 24'hFF0F00);
	prog[0][7] = encode(pp_isa_pkg::op_stwr,  24'h000110);
	prog[0][8] = encode(pp_isa_pkg::op_stop,  24'h000000);
	prog_len[0] = 9;
	data_addr[0][0] = 14'h100;
	data_val[0][0]  = 32'h00010000;
	data_addr[0][1] = 14'h101;
	data_val[0][1]  = 32'h34;
	data_addr[0][2] = 14'h102;
	data_val[0][2]  = 32'd3;
	data_addr[0][3] = 14'h103;
	data_val[0][3]  = 32'd14;
	stim[0]    = '{8'd0, 1'b0, 16'd0, 16'd0};
	exp_res[0] = '{32'h000C0800, 14'h110, 32'h000C0800, 4'h0};

	// countdown loop, then one test per branch kind
	prog[1][0]  = encode(pp_isa_pkg::op_ldwrd, 24'd5);
	prog[1][1]  = encode(pp_isa_pkg::op_subd,  24'd1);
	prog[1][2]  = encode(pp_isa_pkg::op_cmpd,  24'd0);
	prog[1][3]  = encode(pp_isa_pkg::op_jmpnz, 24'd1);
	prog[1][4]  = encode(pp_isa_pkg::op_cmpd,  24'd0);
	prog[1][5]  = encode(pp_isa_pkg::op_jmpgz, 24'd7);     // not taken
	prog[1][6]  = encode(pp_isa_pkg::op_addwd, 24'h10);
	prog[1][7]  = encode(pp_isa_pkg::op_cmpd,  24'h20);
	prog[1][8]  = encode(pp_isa_pkg::op_jmplz, 24'd10);    // taken
	prog[1][9]  = encode(pp_isa_pkg::op_addwd, 24'h100);
	prog[1][10] = encode(pp_isa_pkg::op_jmpge, 24'd12);    // not taken
	prog[1][11] = encode(pp_isa_pkg::op_addwd, 24'h1000);
	prog[1][12] = encode(pp_isa_pkg::op_jmple, 24'd14);    // taken
	prog[1][13] = encode(pp_isa_pkg::op_addwd, 24'h10000);
	prog[1][14] = encode(pp_isa_pkg::op_stwr,  24'h000110);
	prog[1][15] = encode(pp_isa_pkg::op_stop,  24'h000000);
	prog_len[1] = 16;
	stim[1]    = '{8'd0, 1'b0, 16'd0, 16'd40};
	exp_res[1] = '{32'h00001010, 14'h110, 32'h00001010, 4'h0};

	// indirect access through INDF
	prog[2][0] = encode(pp_isa_pkg::op_ldindf, 24'h000100);
	prog[2][1] = encode(pp_isa_pkg::op_ldwi,   24'h000000);
	prog[2][2] = encode(pp_isa_pkg::op_addwd,  24'h000001);
	prog[2][3] = encode(pp_isa_pkg::op_ldindf, 24'h000101);
	prog[2][4] = encode(pp_isa_pkg::op_stwi,   24'h000000);
	prog[2][5] = encode(pp_isa_pkg::op_stop,   24'h000000);
	prog_len[2] = 6;
	data_addr[2][0] = 14'h100;
	data_val[2][0]  = 32'h120;
	data_addr[2][1] = 14'h101;
	data_val[2][1]  = 32'h130;
	data_addr[2][2] = 14'h120;
	data_val[2][2]  = 32'hABCDEF01;
	stim[2]    = '{8'd0, 1'b0, 16'd0, 16'd0};
	exp_res[2] = '{32'hABCDEF02, 14'h130, 32'hABCDEF02, 4'h0};

	// DDS commands of every kind under back-pressure, shutter
	prog[3][0] = encode(pp_isa_pkg::op_ddsfrq,  24'h200100);
	prog[3][1] = encode(pp_isa_pkg::op_shutter, 24'h000005);
	prog[3][2] = encode(pp_isa_pkg::op_ddsamp,  24'h300101);
	prog[3][3] = encode(pp_isa_pkg::op_ddsphs,  24'h100102);
	prog[3][4] = encode(pp_isa_pkg::op_ddschn,  24'hA70000);
	prog[3][5] = encode(pp_isa_pkg::op_shutter, 24'h00000C);
	prog[3][6] = encode(pp_isa_pkg::op_ldwrd,   24'h000042);
	prog[3][7] = encode(pp_isa_pkg::op_stwr,    24'h000110);
	prog[3][8] = encode(pp_isa_pkg::op_stop,    24'h000000);
	prog_len[3] = 9;
	data_addr[3][0] = 14'h100;
	data_val[3][0]  = 32'h12345678;
	data_addr[3][1] = 14'h101;
	data_val[3][1]  = 32'hFFFFFFFF;
	data_addr[3][2] = 14'h102;
	data_val[3][2]  = 32'hFFFFABCD;
	stim[3]    = '{8'd64, 1'b0, 16'd0, 16'd0};
	exp_res[3] = '{32'h42, 14'h110, 32'h42, 4'hC};
	num_dds[3]    = 4;
	exp_dds[3][0] = '{4'h2, pp_io_pkg::dds_frq, 32'h12345678};
	exp_dds[3][1] = '{4'h3, pp_io_pkg::dds_amp, 32'h000003FF};   // 10 bits
	exp_dds[3][2] = '{4'h1, pp_io_pkg::dds_phs, 32'h00002BCD};   // 14 bits
	exp_dds[3][3] = '{4'hA, pp_io_pkg::dds_chn, 32'h00000007};

	// photon counting, pmt high then low
	for (r = 4; r < 6; r++)
	begin
		prog[r][0] = encode(pp_isa_pkg::op_countd, 24'd10);
		prog[r][1] = encode(pp_isa_pkg::op_stwr,   24'h000110);
		prog[r][2] = encode(pp_isa_pkg::op_stop,   24'h000000);
		prog_len[r] = 3;
	end
	stim[4]    = '{8'd0, 1'b1, 16'd0, 16'd10};
	exp_res[4] = '{32'd10, 14'h110, 32'd10, 4'hC};
	stim[5]    = '{8'd0, 1'b0, 16'd0, 16'd10};
	exp_res[5] = '{32'd0, 14'h110, 32'd0, 4'hC};

	// long delay, stopped by stop_i, then run to the end
	for (r = 6; r < 8; r++)
	begin
		prog[r][0] = encode(pp_isa_pkg::op_ldwrd,  24'd7);
		prog[r][1] = encode(pp_isa_pkg::op_delayd, 24'd2000);
		prog[r][2] = encode(pp_isa_pkg::op_addwd,  24'd1);
		prog[r][3] = encode(pp_isa_pkg::op_stwr,   24'h000110);
		prog[r][4] = encode(pp_isa_pkg::op_stop,   24'h000000);
		prog_len[r] = 5;
	end
	stim[6]    = '{8'd0, 1'b0, 16'd40, 16'd2000};
	exp_res[6] = '{32'd7, 14'h110, fill_word(14'h110), 4'hC};   // store never reached
	stim[7]    = '{8'd0, 1'b0, 16'd0, 16'd2000};
	exp_res[7] = '{32'd8, 14'h110, 32'd8, 4'hC};
endtask

`endif

// ==== tb_pp_core.sv ====
`default_nettype none

module tb_pp_core;

	localparam int ADDR_W    = 14;
	localparam int MEM_WORDS = 1 << ADDR_W;

	logic                clk_i = 1'b0;
	logic                reset_i;
	logic                start_i;
	logic                stop_i;
	logic                pmt_i;
	logic [ADDR_W-1:0]   mem_addr_o;
	logic                mem_we_o;
	pp_io_pkg::word_t    mem_wdata_o;
	pp_io_pkg::word_t    mem_rdata_i;
	logic                dds_valid_o;
	pp_io_pkg::dds_cmd_t dds_cmd_o;
	logic                dds_ready_i;
	pp_io_pkg::shutter_t shutter_o;
	logic                pp_active_o;
	logic [ADDR_W-1:0]   pc_o;
	pp_io_pkg::word_t    w_o;

	pp_io_pkg::word_t    mem [MEM_WORDS];
	pp_io_pkg::dds_cmd_t dds_seen [$];   // commands taken by the board
	logic [15:0]         lfsr_q;
	int                  cur_bp;
	int                  rnd;
	int                  cycle_cnt;
	int                  cycle_limit;

	function automatic pp_io_pkg::word_t fill_word(input logic [13:0] a);
		fill_word = {4'hC, a, ~a};
	endfunction

	function automatic pp_io_pkg::word_t encode(input pp_isa_pkg::opcode_t op,
		input pp_isa_pkg::imm_t d);
		encode = {op, d};
	endfunction

	`include "tb_pp_programs.svh"

	pp_core #(.ADDR_W(ADDR_W)) pp_core_inst
	(
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.start_i     (start_i),
		.stop_i      (stop_i),
		.pmt_i       (pmt_i),
		.mem_addr_o  (mem_addr_o),
		.mem_we_o    (mem_we_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_rdata_i (mem_rdata_i),
		.dds_valid_o (dds_valid_o),
		.dds_cmd_o   (dds_cmd_o),
		.dds_ready_i (dds_ready_i),
		.shutter_o   (shutter_o),
		.pp_active_o (pp_active_o),
		.pc_o        (pc_o),
		.w_o         (w_o)
	);

	always #20 clk_i = ~clk_i;

	////////////////////////////////////////////////////////////
	// program memory, board side and run limit
	////////////////////////////////////////////////////////////

	always @(posedge clk_i)
	begin
		if (mem_we_o)
			mem[mem_addr_o] <= mem_wdata_o;
		mem_rdata_i <= mem[mem_addr_o];   // one cycle read latency
	end

	always @(posedge clk_i)
	begin
		if (!reset_i && dds_valid_o && dds_ready_i)
			dds_seen.push_back(dds_cmd_o);
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int val);
		int k;
		val = 0;
		for (k = 0; k < n; k++)
		begin
			val    = (val << 1) | lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	always @(negedge clk_i)
	begin
		draw_bits(7, rnd);
		dds_ready_i = (rnd >= cur_bp);
	end

	always @(posedge clk_i)
	begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
		begin
			$display("timeout: the run took more than %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1, "run limit reached");
		end
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input pp_io_pkg::word_t got,
		input pp_io_pkg::word_t exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_dds(input string name, input pp_io_pkg::dds_cmd_t got,
		input pp_io_pkg::dds_cmd_t exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_shutter(input string name, input pp_io_pkg::shutter_t got,
		input pp_io_pkg::shutter_t exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_pc(input string name, input logic [ADDR_W-1:0] got,
		input logic [ADDR_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic run_row(input int r);
		int a;
		int k;
		int elapsed;
		@(negedge clk_i);
		for (a = 0; a < MEM_WORDS; a++)
			mem[a] = fill_word(a[13:0]);
		for (k = 0; k < prog_len[r]; k++)
			mem[k] = prog[r][k];
		for (k = 0; k < NUM_DATA; k++)
			mem[data_addr[r][k]] = data_val[r][k];
		pmt_i  = stim[r].pmt;
		cur_bp = stim[r].bp_lvl;
		dds_seen.delete();

		start_i = 1'b1;
		@(negedge clk_i);
		start_i = 1'b0;
		if (!pp_active_o)
			fail_run($sformatf("row %0d: pp_active_o did not rise after start_i", r));
		check_word("w_o at start", w_o, '0);
		check_pc("pc_o at start", pc_o, '0);

		elapsed = 1;
		while (pp_active_o)   // bounded by the run limit
		begin
			stop_i = (stim[r].stop_at != 0) && (elapsed == stim[r].stop_at);
			@(negedge clk_i);
			elapsed++;
		end
		stop_i = 1'b0;
		if (stim[r].stop_at != 0 && elapsed != stim[r].stop_at + 1)
			fail_run($sformatf("row %0d: pp_active_o did not fall right after stop_i", r));

		// W is still held for one cycle in stop
		check_word("w_o", w_o, exp_res[r].w);
		while (dds_valid_o)
			@(negedge clk_i);
		check_shutter("shutter_o", shutter_o, exp_res[r].shutter);
		check_word("mem", mem[exp_res[r].addr], exp_res[r].val);
		if (dds_seen.size() != num_dds[r])
			fail_run($sformatf("row %0d: board took %0d DDS commands, %0d expected",
				r, dds_seen.size(), num_dds[r]));
		for (k = 0; k < num_dds[r]; k++)
			check_dds("dds_cmd_o", dds_seen[k], exp_dds[r][k]);
	endtask

	initial
	begin
		int r;
		int total;
		reset_i     = 1'b1;
		start_i     = 1'b0;
		stop_i      = 1'b0;
		pmt_i       = 1'b0;
		mem_rdata_i = '0;
		dds_ready_i = 1'b0;
		lfsr_q      = 16'd27162;
		cur_bp      = 0;
		cycle_cnt   = 0;
		cycle_limit = 1000000;
		load_table();
		total = 0;
		for (r = 0; r < NUM_ROWS; r++)
			total += prog_len[r] + stim[r].delay;
		cycle_limit = 10 * total;

		repeat (8) @(negedge clk_i);
		reset_i = 1'b0;
		@(negedge clk_i);
		if (pp_active_o || mem_we_o || dds_valid_o)
			fail_run("core not idle after reset");
		check_shutter("shutter_o after reset", shutter_o, '0);
		check_word("w_o after reset", w_o, '0);

		for (r = 0; r < NUM_ROWS; r++)
			run_row(r);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pp_core.sv ====
`default_nettype none

module pp_core
#(
	parameter int ADDR_W = 14
)
(
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 start_i,
	input  wire                 stop_i,
	input  wire                 pmt_i,
	output logic [ADDR_W-1:0]   mem_addr_o,
	output logic                mem_we_o,
	output pp_io_pkg::word_t    mem_wdata_o,
	input  pp_io_pkg::word_t    mem_rdata_i,
	output logic                dds_valid_o,
	output pp_io_pkg::dds_cmd_t dds_cmd_o,
	input  wire                 dds_ready_i,
	output pp_io_pkg::shutter_t shutter_o,
	output logic                pp_active_o,
	output logic [ADDR_W-1:0]   pc_o,
	output pp_io_pkg::word_t    w_o
);

	pp_isa_pkg::instr_t   instr;
	pp_isa_pkg::decoded_t dec;
	pp_io_pkg::word_t     operand;
	logic [ADDR_W-1:0]    indf;
	logic                 take_jump;
	logic                 exec_en;
	logic                 count_en;
	logic                 clear;
	logic                 shutter_we;
	logic                 seq_dds_valid;   // sequencer to output stage
	logic                 seq_dds_ready;
	pp_io_pkg::dds_cmd_t  seq_dds_cmd;

	pp_decode pp_decode_inst
	(
		.instr_i (instr),
		.dec_o   (dec)
	);

	pp_execute #(.ADDR_W(ADDR_W)) pp_execute_inst
	(
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.exec_en_i   (exec_en),
		.count_en_i  (count_en),
		.pmt_i       (pmt_i),
		.dec_i       (dec),
		.imm_i       (instr.data),
		.operand_i   (operand),
		.clear_i     (clear),
		.w_o         (w_o),
		.indf_o      (indf),
		.take_jump_o (take_jump)
	);

	pp_sequencer #(.ADDR_W(ADDR_W)) pp_sequencer_inst
	(
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.start_i      (start_i),
		.stop_i       (stop_i),
		.mem_rdata_i  (mem_rdata_i),
		.mem_addr_o   (mem_addr_o),
		.mem_we_o     (mem_we_o),
		.mem_wdata_o  (mem_wdata_o),
		.dec_i        (dec),
		.instr_o      (instr),
		.w_i          (w_o),
		.indf_i       (indf),
		.take_jump_i  (take_jump),
		.exec_en_o    (exec_en),
		.count_en_o   (count_en),
		.clear_o      (clear),
		.operand_o    (operand),
		.dds_valid_o  (seq_dds_valid),
		.dds_cmd_o    (seq_dds_cmd),
		.dds_ready_i  (seq_dds_ready),
		.shutter_we_o (shutter_we),
		.pc_o         (pc_o),
		.active_o     (pp_active_o)
	);

	pp_output_stage pp_output_stage_inst
	(
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.shutter_we_i (shutter_we),
		.shutter_i    (instr.data[3:0]),   // shutter bits of the data field
		.shutter_o    (shutter_o),
		.cmd_valid_i  (seq_dds_valid),
		.cmd_i        (seq_dds_cmd),
		.cmd_ready_o  (seq_dds_ready),
		.dds_valid_o  (dds_valid_o),
		.dds_cmd_o    (dds_cmd_o),
		.dds_ready_i  (dds_ready_i)
	);

endmodule

`default_nettype wire

// ==== pp_output_stage.sv ====
`default_nettype none

module pp_output_stage
(
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 shutter_we_i,
	input  pp_io_pkg::shutter_t shutter_i,
	output pp_io_pkg::shutter_t shutter_o,
	input  wire                 cmd_valid_i,
	input  pp_io_pkg::dds_cmd_t cmd_i,
	output logic                cmd_ready_o,
	output logic                dds_valid_o,
	output pp_io_pkg::dds_cmd_t dds_cmd_o,
	input  wire                 dds_ready_i
);

	pp_io_pkg::shutter_t shutter_q;
	pp_io_pkg::dds_cmd_t cmd_q;      // held toward the board
	logic                full_q;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			shutter_q <= '0;
			full_q    <= 1'b0;
		end
		else
		begin
			if (shutter_we_i)
				shutter_q <= shutter_i;
			if (!full_q)
				full_q <= cmd_valid_i;
			else if (dds_ready_i)
				full_q <= 1'b0;   // board took it
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (cmd_valid_i && !full_q)
			cmd_q <= cmd_i;
	end

	assign cmd_ready_o = !full_q;   // single entry
	assign dds_valid_o = full_q;
	assign dds_cmd_o   = cmd_q;
	assign shutter_o   = shutter_q;

endmodule

`default_nettype wire

// ==== pp_sequencer.sv ====
`default_nettype none

module pp_sequencer
#(
	parameter int ADDR_W = 14
)
(
	input  wire                  clk_i,
	input  wire                  reset_i,
	input  wire                  start_i,
	input  wire                  stop_i,
	input  pp_io_pkg::word_t     mem_rdata_i,
	output logic [ADDR_W-1:0]    mem_addr_o,
	output logic                 mem_we_o,
	output pp_io_pkg::word_t     mem_wdata_o,
	input  pp_isa_pkg::decoded_t dec_i,
	output pp_isa_pkg::instr_t   instr_o,
	input  pp_io_pkg::word_t     w_i,
	input  wire [ADDR_W-1:0]     indf_i,
	input  wire                  take_jump_i,
	output logic                 exec_en_o,
	output logic                 count_en_o,
	output logic                 clear_o,
	output pp_io_pkg::word_t     operand_o,
	output logic                 dds_valid_o,
	output pp_io_pkg::dds_cmd_t  dds_cmd_o,
	input  wire                  dds_ready_i,
	output logic                 shutter_we_o,
	output logic [ADDR_W-1:0]    pc_o,
	output logic                 active_o
);

	pp_io_pkg::seq_state_t state_q;
	pp_io_pkg::seq_state_t state_d;
	logic [ADDR_W-1:0]     pc_q;
	pp_isa_pkg::imm_t      delay_q;      // wait cycles left
	pp_isa_pkg::imm_t      delay_n;
	pp_isa_pkg::imm_t      delay_load;
	pp_isa_pkg::instr_t    instr_q;
	pp_io_pkg::dds_cmd_t   dds_cmd_q;
	pp_io_pkg::dds_cmd_t   dds_cmd_d;

	// in setup the word comes straight from memory
	assign instr_o = (state_q == pp_io_pkg::seq_setup) ?
		pp_isa_pkg::instr_t'(mem_rdata_i) : instr_q;

	assign delay_n    = dec_i.use_imm ? instr_o.data : mem_rdata_i[23:0];
	assign delay_load = dec_i.count ? delay_n :
		(delay_n == '0) ? '0 : delay_n - 24'd1;   // delay n waits n-1

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			pp_io_pkg::seq_stop:
				if (start_i)
					state_d = pp_io_pkg::seq_fetch;
			pp_io_pkg::seq_fetch: state_d = pp_io_pkg::seq_setup;
			pp_io_pkg::seq_setup: state_d = pp_io_pkg::seq_exec;
			pp_io_pkg::seq_exec:
				if (dec_i.stop)
					state_d = pp_io_pkg::seq_stop;
				else if (dec_i.dds)
					state_d = pp_io_pkg::seq_dds_wait;
				else if ((dec_i.delay || dec_i.count) && delay_load != '0)
					state_d = pp_io_pkg::seq_wait;
				else
					state_d = pp_io_pkg::seq_fetch;
			pp_io_pkg::seq_wait:
				if (delay_q <= 24'd1)
					state_d = pp_io_pkg::seq_fetch;
			pp_io_pkg::seq_dds_wait:
				if (dds_ready_i)
					state_d = pp_io_pkg::seq_fetch;   // accepted this cycle
			default: state_d = pp_io_pkg::seq_stop;
		endcase
		if (stop_i)
			state_d = pp_io_pkg::seq_stop;
	end

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q <= pp_io_pkg::seq_stop;
			pc_q    <= '0;
			delay_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			case (state_q)
				pp_io_pkg::seq_stop:
				begin
					pc_q    <= '0;
					delay_q <= '0;
				end
				pp_io_pkg::seq_exec:
				begin
					pc_q    <= take_jump_i ? instr_o.data[ADDR_W-1:0] : pc_q + 1'b1;
					delay_q <= delay_load;
				end
				pp_io_pkg::seq_wait: delay_q <= delay_q - 24'd1;
				default: ;
			endcase
		end
	end

	// DDS command, payload masked by kind
	always_comb
	begin
		dds_cmd_d.board = instr_o.data[23:20];
		dds_cmd_d.kind  = dec_i.dds_kind;
		case (dec_i.dds_kind)
			pp_io_pkg::dds_frq: dds_cmd_d.payload = mem_rdata_i;
			pp_io_pkg::dds_amp: dds_cmd_d.payload = {22'd0, mem_rdata_i[9:0]};
			pp_io_pkg::dds_phs: dds_cmd_d.payload = {18'd0, mem_rdata_i[13:0]};
			default:            dds_cmd_d.payload = {28'd0, instr_o.data[19:16]};
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (state_q == pp_io_pkg::seq_setup)
			instr_q <= pp_isa_pkg::instr_t'(mem_rdata_i);
		if (state_q == pp_io_pkg::seq_exec)
			dds_cmd_q <= dds_cmd_d;
	end

	// memory port
	assign mem_addr_o  = (state_q != pp_io_pkg::seq_setup) ? pc_q :
		dec_i.indirect ? indf_i : instr_o.data[ADDR_W-1:0];
	assign mem_we_o    = (state_q == pp_io_pkg::seq_setup) && dec_i.store;
	assign mem_wdata_o = w_i;

	assign operand_o    = mem_rdata_i;   // valid in exec
	assign exec_en_o    = (state_q == pp_io_pkg::seq_exec);
	assign count_en_o   = (state_q == pp_io_pkg::seq_wait) && dec_i.count;
	assign clear_o      = (state_q == pp_io_pkg::seq_stop);
	assign shutter_we_o = exec_en_o && dec_i.shutter;
	assign dds_valid_o  = (state_q == pp_io_pkg::seq_dds_wait);
	assign dds_cmd_o    = dds_cmd_q;
	assign pc_o         = pc_q;
	assign active_o     = (state_q != pp_io_pkg::seq_stop);

endmodule

`default_nettype wire

// ==== pp_execute.sv ====
`default_nettype none

module pp_execute
#(
	parameter int ADDR_W = 14
)
(
	input  wire                  clk_i,
	input  wire                  reset_i,
	input  wire                  exec_en_i,
	input  wire                  count_en_i,
	input  wire                  pmt_i,
	input  pp_isa_pkg::decoded_t dec_i,
	input  pp_isa_pkg::imm_t     imm_i,
	input  pp_io_pkg::word_t     operand_i,
	input  wire                  clear_i,
	output pp_io_pkg::word_t     w_o,
	output logic [ADDR_W-1:0]    indf_o,
	output logic                 take_jump_o
);

	pp_io_pkg::word_t  w_q;
	logic [ADDR_W-1:0] indf_q;
	logic              cmp_gt_q;     // W > operand at last cmp
	logic              cmp_lt_q;
	logic              cmp_eq;
	pp_io_pkg::word_t  opnd;

	assign opnd   = dec_i.use_imm ? {8'h00, imm_i} : operand_i;   // zero extended
	assign cmp_eq = !cmp_gt_q && !cmp_lt_q;

	////////////////////////////////////////////////////////////
	// W, INDF and compare flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (reset_i || clear_i)
		begin
			w_q      <= '0;
			indf_q   <= '0;
			cmp_gt_q <= 1'b0;
			cmp_lt_q <= 1'b0;
		end
		else if (count_en_i)
			w_q <= w_q + {31'd0, pmt_i};   // one photon per cycle at most
		else if (exec_en_i)
		begin
			if (dec_i.count)
				w_q <= '0;
			case (dec_i.alu_op)
				pp_isa_pkg::alu_load:  w_q <= opnd;
				pp_isa_pkg::alu_and:   w_q <= w_q & opnd;
				pp_isa_pkg::alu_add:   w_q <= w_q + opnd;
				pp_isa_pkg::alu_sub:   w_q <= w_q - opnd;
				pp_isa_pkg::alu_mul:   w_q <= w_q * opnd;     // low 32 bits
				pp_isa_pkg::alu_inc:   w_q <= opnd + 32'd1;
				pp_isa_pkg::alu_dec:   w_q <= opnd - 32'd1;
				pp_isa_pkg::alu_shl:   w_q <= w_q << opnd;
				pp_isa_pkg::alu_shr_a: w_q <= $signed(w_q) >>> opnd;
				pp_isa_pkg::alu_shr_l: w_q <= w_q >> opnd;
				pp_isa_pkg::alu_clr:   w_q <= '0;
				pp_isa_pkg::alu_ldindf: indf_q <= opnd[ADDR_W-1:0];
				pp_isa_pkg::alu_cmp:
				begin
					cmp_gt_q <= $signed(w_q) > $signed(opnd);
					cmp_lt_q <= $signed(w_q) < $signed(opnd);
				end
				default: ;
			endcase
		end
	end

	// jump test against the flags of the last cmp
	always_comb
	begin
		case (dec_i.jump_cond)
			pp_isa_pkg::jc_always: take_jump_o = 1'b1;
			pp_isa_pkg::jc_z:      take_jump_o = cmp_eq;
			pp_isa_pkg::jc_nz:     take_jump_o = !cmp_eq;
			pp_isa_pkg::jc_gz:     take_jump_o = cmp_gt_q;
			pp_isa_pkg::jc_lz:     take_jump_o = cmp_lt_q;
			pp_isa_pkg::jc_ge:     take_jump_o = !cmp_lt_q;
			pp_isa_pkg::jc_le:     take_jump_o = !cmp_gt_q;
			default:               take_jump_o = 1'b0;
		endcase
	end

	assign w_o    = w_q;
	assign indf_o = indf_q;

endmodule

`default_nettype wire

// ==== pp_decode.sv ====
`default_nettype none

module pp_decode
(
	input  pp_isa_pkg::instr_t   instr_i,
	output pp_isa_pkg::decoded_t dec_o
);

	always_comb
	begin
		dec_o = '0;   // unknown opcodes fall through as nop

		case (instr_i.opcode)
			pp_isa_pkg::op_ddsfrq:
			begin
				dec_o.dds      = 1'b1;
				dec_o.dds_kind = pp_io_pkg::dds_frq;
			end
			pp_isa_pkg::op_ddsamp:
			begin
				dec_o.dds      = 1'b1;
				dec_o.dds_kind = pp_io_pkg::dds_amp;
			end
			pp_isa_pkg::op_ddsphs:
			begin
				dec_o.dds      = 1'b1;
				dec_o.dds_kind = pp_io_pkg::dds_phs;
			end
			pp_isa_pkg::op_ddschn:
			begin
				dec_o.dds      = 1'b1;
				dec_o.dds_kind = pp_io_pkg::dds_chn;
			end
			pp_isa_pkg::op_shutter: dec_o.shutter = 1'b1;
			pp_isa_pkg::op_count, pp_isa_pkg::op_countd: dec_o.count = 1'b1;
			pp_isa_pkg::op_delay, pp_isa_pkg::op_delayd: dec_o.delay = 1'b1;
			pp_isa_pkg::op_ldwr, pp_isa_pkg::op_ldwrd: dec_o.alu_op = pp_isa_pkg::alu_load;
			pp_isa_pkg::op_ldwi:
			begin
				dec_o.alu_op   = pp_isa_pkg::alu_load;
				dec_o.indirect = 1'b1;
			end
			pp_isa_pkg::op_stwr: dec_o.store = 1'b1;
			pp_isa_pkg::op_stwi:
			begin
				dec_o.store    = 1'b1;
				dec_o.indirect = 1'b1;
			end
			pp_isa_pkg::op_ldindf: dec_o.alu_op = pp_isa_pkg::alu_ldindf;
			pp_isa_pkg::op_andw, pp_isa_pkg::op_andwd: dec_o.alu_op = pp_isa_pkg::alu_and;
			pp_isa_pkg::op_addw, pp_isa_pkg::op_addwd: dec_o.alu_op = pp_isa_pkg::alu_add;
			pp_isa_pkg::op_sub, pp_isa_pkg::op_subd: dec_o.alu_op = pp_isa_pkg::alu_sub;
			pp_isa_pkg::op_mul, pp_isa_pkg::op_muld: dec_o.alu_op = pp_isa_pkg::alu_mul;
			pp_isa_pkg::op_shl, pp_isa_pkg::op_shld: dec_o.alu_op = pp_isa_pkg::alu_shl;
			pp_isa_pkg::op_shr: dec_o.alu_op = pp_isa_pkg::alu_shr_a;
			pp_isa_pkg::op_shrd: dec_o.alu_op = pp_isa_pkg::alu_shr_l;
			pp_isa_pkg::op_inc: dec_o.alu_op = pp_isa_pkg::alu_inc;
			pp_isa_pkg::op_dec: dec_o.alu_op = pp_isa_pkg::alu_dec;
			pp_isa_pkg::op_clrw: dec_o.alu_op = pp_isa_pkg::alu_clr;
			pp_isa_pkg::op_cmp, pp_isa_pkg::op_cmpd: dec_o.alu_op = pp_isa_pkg::alu_cmp;
			pp_isa_pkg::op_jmp: dec_o.jump_cond = pp_isa_pkg::jc_always;
			pp_isa_pkg::op_jmpz: dec_o.jump_cond = pp_isa_pkg::jc_z;
			pp_isa_pkg::op_jmpnz: dec_o.jump_cond = pp_isa_pkg::jc_nz;
			pp_isa_pkg::op_jmpgz: dec_o.jump_cond = pp_isa_pkg::jc_gz;
			pp_isa_pkg::op_jmplz: dec_o.jump_cond = pp_isa_pkg::jc_lz;
			pp_isa_pkg::op_jmpge: dec_o.jump_cond = pp_isa_pkg::jc_ge;
			pp_isa_pkg::op_jmple: dec_o.jump_cond = pp_isa_pkg::jc_le;
			pp_isa_pkg::op_stop: dec_o.stop = 1'b1;
			default: ;
		endcase

		// immediate forms
		case (instr_i.opcode)
			pp_isa_pkg::op_countd, pp_isa_pkg::op_delayd, pp_isa_pkg::op_ldwrd,
			pp_isa_pkg::op_andwd, pp_isa_pkg::op_addwd, pp_isa_pkg::op_cmpd,
			pp_isa_pkg::op_muld, pp_isa_pkg::op_subd, pp_isa_pkg::op_shld,
			pp_isa_pkg::op_shrd:
				dec_o.use_imm = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== pp_isa_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// instruction set
////////////////////////////////////////////////////////////

package pp_isa_pkg;

	// names ending in d take the data field as operand
	typedef enum logic [7:0]
	{
		op_nop    = 8'h00,
		op_ddsfrq = 8'h01,
		op_ddsamp = 8'h02,
		op_ddsphs = 8'h03,
		op_ddschn = 8'h04,
		op_shutter = 8'h05,
		op_count  = 8'h06,
		op_countd = 8'h07,
		op_delay  = 8'h08,
		op_delayd = 8'h09,
		op_ldwr   = 8'h0A,
		op_ldwrd  = 8'h0B,
		op_ldwi   = 8'h0C,
		op_stwr   = 8'h0D,
		op_stwi   = 8'h0E,
		op_ldindf = 8'h0F,
		op_andw   = 8'h10,
		op_andwd  = 8'h11,
		op_addw   = 8'h12,
		op_addwd  = 8'h13,
		op_inc    = 8'h14,
		op_dec    = 8'h15,
		op_clrw   = 8'h16,
		op_cmp    = 8'h17,
		op_cmpd   = 8'h18,
		op_jmp    = 8'h19,
		op_jmpz   = 8'h1A,
		op_jmpnz  = 8'h1B,
		op_mul    = 8'h1C,
		op_muld   = 8'h1D,
		op_sub    = 8'h1E,
		op_subd   = 8'h1F,
		op_shl    = 8'h20,
		op_shld   = 8'h21,
		op_shr    = 8'h22,     // arithmetic
		op_shrd   = 8'h23,     // logical
		op_jmpgz  = 8'h29,
		op_jmplz  = 8'h2A,
		op_jmpge  = 8'h2B,
		op_jmple  = 8'h2C,
		op_stop   = 8'hFF
	} opcode_t;

	typedef logic [23:0] imm_t;   // data field, also delay count

	typedef struct packed
	{
		opcode_t opcode;
		imm_t    data;
	} instr_t;

	typedef enum logic [3:0]
	{
		alu_none, alu_load, alu_and, alu_add, alu_sub, alu_mul, alu_inc,
		alu_dec, alu_shl, alu_shr_a, alu_shr_l, alu_clr, alu_cmp, alu_ldindf
	} alu_op_t;

	typedef enum logic [2:0]
	{
		jc_never, jc_always, jc_z, jc_nz, jc_gz, jc_lz, jc_ge, jc_le
	} jump_cond_t;

	typedef struct packed
	{
		alu_op_t              alu_op;
		logic                 use_imm;    // operand is the data field
		logic                 indirect;   // operand address from INDF
		jump_cond_t           jump_cond;
		logic                 store;      // W to memory in setup
		logic                 delay;
		logic                 count;
		logic                 dds;
		pp_io_pkg::dds_kind_t dds_kind;
		logic                 shutter;
		logic                 stop;
	} decoded_t;

endpackage

`default_nettype wire

// ==== pp_io_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// data path and DDS board types
////////////////////////////////////////////////////////////

package pp_io_pkg;

	typedef logic [31:0] word_t;        // W and memory data
	typedef logic [3:0]  shutter_t;     // BNC shutter lines
	typedef logic [3:0]  dds_board_t;   // board select

	typedef enum logic [1:0]
	{
		dds_frq = 2'd0,
		dds_amp = 2'd1,
		dds_phs = 2'd2,
		dds_chn = 2'd3
	} dds_kind_t;

	// one command toward the DDS boards, 38 bits
	typedef struct packed
	{
		dds_board_t board;
		dds_kind_t  kind;
		word_t      payload;
	} dds_cmd_t;

	typedef enum logic [2:0]
	{
		seq_stop     = 3'd0,
		seq_fetch    = 3'd1,
		seq_setup    = 3'd2,
		seq_exec     = 3'd3,
		seq_wait     = 3'd4,
		seq_dds_wait = 3'd5
	} seq_state_t;

endpackage

`default_nettype wire
